// File: design/ooo_pkg.sv
// Out-of-order core shared definitions: sizes, opcodes, ALU codes and packet types
package ooo_pkg;

    // ========================================================================
    // Widths and sizes
    // ========================================================================
    localparam int xlen            = 32;
    localparam int num_arch_regs   = 32;
    localparam int num_phys_regs   = 64;
    localparam int phys_tag_width  = 6;
    localparam int arch_addr_width = 5;
    localparam int iq_depth        = 8;
    localparam int iq_idx_width    = 3;
    localparam int rob_depth       = 16;
    localparam int rob_ptr_width   = 4;
    // Free list holds at most the registers beyond the architectural set
    localparam int free_list_depth = num_phys_regs - num_arch_regs;
    localparam int free_ptr_width  = 5;

    // RV32I ALU opcodes
    localparam logic [6:0] opcode_op     = 7'b0110011;
    localparam logic [6:0] opcode_op_imm = 7'b0010011;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra
    } alu_op_t;

    // ========================================================================
    // Instruction word, register-register or register-immediate view
    // ========================================================================
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fields_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fields_t;

    typedef union packed {
        r_fields_t r_fields;
        i_fields_t i_fields;
    } instr_word_u;

    // Dispatch packet, shared by issue queue and ROB
    typedef struct packed {
        alu_op_t                    op;
        logic [phys_tag_width-1:0]  src1_tag;
        logic                       src1_ready;
        logic [phys_tag_width-1:0]  src2_tag;
        logic                       src2_ready;
        logic                       use_imm;
        logic [xlen-1:0]            imm;
        logic [phys_tag_width-1:0]  dst_tag;
        // ROB only
        logic [arch_addr_width-1:0] arch_rd;
        logic [phys_tag_width-1:0]  old_tag;
        logic                       writes_reg;
    } dispatch_t;

    // Common data bus
    typedef struct packed {
        logic                      valid;
        logic [phys_tag_width-1:0] tag;
        logic [xlen-1:0]           value;
    } cdb_t;

    typedef struct packed {
        logic                      valid;
        alu_op_t                   op;
        logic [phys_tag_width-1:0] src1_tag;
        logic [phys_tag_width-1:0] src2_tag;
        logic [xlen-1:0]           imm;
        logic                      use_imm;
        logic [phys_tag_width-1:0] dst_tag;
    } issue_t;

endpackage

// File: design/rename_stage.sv
// Rename stage: decodes ALU instructions and maps registers via alias table and free list
`timescale 1ns/1ps

module rename_stage (
    input  logic                                    clk,
    input  logic                                    reset,
    input  ooo_pkg::instr_word_u                    instr,
    input  logic                                    accept,
    input  logic [1:0]                              src_ready,
    output logic [1:0][ooo_pkg::phys_tag_width-1:0] src_tags,
    input  logic                                    free_en,
    input  logic [ooo_pkg::phys_tag_width-1:0]      free_tag,
    output logic                                    free_empty,
    output logic                                    disp_valid,
    output ooo_pkg::dispatch_t                      disp
);
    import ooo_pkg::*;

    logic [phys_tag_width-1:0] alias_table [num_arch_regs];
    logic [phys_tag_width-1:0] free_list [free_list_depth];
    logic [free_ptr_width-1:0] free_head;
    logic [free_ptr_width-1:0] free_tail;
    logic [free_ptr_width:0]   free_count;

    logic    is_op;
    logic    is_op_imm;
    logic    alt_bit;
    logic    writes_reg;
    logic    pop;
    alu_op_t alu_op;

    // ========================================================================
    // Decode
    // ========================================================================
    assign is_op     = instr.r_fields.opcode == opcode_op;
    assign is_op_imm = instr.i_fields.opcode == opcode_op_imm;

    // Bit 30 picks sub/sra; for immediates only srai uses it
    assign alt_bit = is_op ? instr.r_fields.funct7[5]
                           : (instr.i_fields.funct3 == 3'b101) && instr.i_fields.imm12[10];

    always_comb begin
        case (instr.r_fields.funct3)
            3'b000:  alu_op = alt_bit ? alu_sub : alu_add;
            3'b001:  alu_op = alu_sll;
            3'b010:  alu_op = alu_slt;
            3'b011:  alu_op = alu_sltu;
            3'b100:  alu_op = alu_xor;
            3'b101:  alu_op = alt_bit ? alu_sra : alu_srl;
            3'b110:  alu_op = alu_or;
            default: alu_op = alu_and;
        endcase
    end

    // x0 destination takes no physical register
    assign writes_reg = instr.r_fields.rd != '0;
    // Unknown opcodes are swallowed
    assign disp_valid = accept && (is_op || is_op_imm);
    assign pop        = disp_valid && writes_reg;
    assign free_empty = free_count == '0;

    // Source lookup with ready bits from the PRF
    assign src_tags[0] = alias_table[instr.r_fields.rs1];
    assign src_tags[1] = alias_table[instr.r_fields.rs2];

    // ========================================================================
    // Dispatch packet
    // ========================================================================
    always_comb begin
        disp.op         = alu_op;
        disp.src1_tag   = src_tags[0];
        disp.src1_ready = src_ready[0];
        // Immediate forms have no second source
        disp.src2_tag   = is_op_imm ? '0 : src_tags[1];
        disp.src2_ready = is_op_imm ? 1'b1 : src_ready[1];
        disp.use_imm    = is_op_imm;
        disp.imm        = {{(xlen - 12){instr.i_fields.imm12[11]}}, instr.i_fields.imm12};
        disp.dst_tag    = writes_reg ? free_list[free_head] : '0;
        disp.arch_rd    = instr.r_fields.rd;
        disp.old_tag    = writes_reg ? alias_table[instr.r_fields.rd] : '0;
        disp.writes_reg = writes_reg;
    end

    // ========================================================================
    // Alias table and circular free list
    // ========================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            // Identity map, upper half of the PRF free
            for (int i = 0; i < num_arch_regs; i++) begin
                alias_table[i] <= phys_tag_width'(i);
            end
            for (int i = 0; i < free_list_depth; i++) begin
                free_list[i] <= phys_tag_width'(num_arch_regs + i);
            end
            free_head  <= '0;
            free_tail  <= '0;
            free_count <= (free_ptr_width + 1)'(free_list_depth);
        end else begin
            if (pop) begin
                alias_table[instr.r_fields.rd] <= free_list[free_head];
                free_head <= free_head + 1'b1;
            end
            // Old mappings return at commit
            if (free_en) begin
                free_list[free_tail] <= free_tag;
                free_tail <= free_tail + 1'b1;
            end
            free_count <= free_count + {{free_ptr_width{1'b0}}, free_en}
                                     - {{free_ptr_width{1'b0}}, pop};
        end
    end

endmodule

// File: design/phys_reg_file.sv
// Physical register file: 64 values with ready bits, rename, issue and commit reads
`timescale 1ns/1ps

module phys_reg_file (
    input  logic                                    clk,
    input  logic                                    reset,
    input  ooo_pkg::cdb_t                           cdb,
    input  logic                                    alloc_en,
    input  logic [ooo_pkg::phys_tag_width-1:0]      alloc_tag,
    input  logic [2:0][ooo_pkg::phys_tag_width-1:0] rd_tags,
    input  logic [1:0][ooo_pkg::phys_tag_width-1:0] issue_tags,
    output logic [1:0]                              ready,
    output logic [1:0][ooo_pkg::xlen-1:0]           issue_values,
    output logic [ooo_pkg::xlen-1:0]                commit_value_out
);
    import ooo_pkg::*;

    logic [xlen-1:0]          values [num_phys_regs];
    logic [num_phys_regs-1:0] ready_bits;

    always_ff @(posedge clk) begin
        if (reset) begin
            // Initial mappings hold zero and are ready
            for (int i = 0; i < num_arch_regs; i++) begin
                values[i] <= '0;
            end
            ready_bits <= {{(num_phys_regs - num_arch_regs){1'b0}}, {num_arch_regs{1'b1}}};
        end else begin
            // Fresh destination waits for its producer
            if (alloc_en && alloc_tag != '0) begin
                ready_bits[alloc_tag] <= 1'b0;
            end
            // Register 0 is constant zero
            if (cdb.valid && cdb.tag != '0) begin
                values[cdb.tag]     <= cdb.value;
                ready_bits[cdb.tag] <= 1'b1;
            end
        end
    end

    // Rename-time ready lookup
    assign ready[0] = ready_bits[rd_tags[0]];
    assign ready[1] = ready_bits[rd_tags[1]];

    // Operand read for the ALU
    assign issue_values[0] = values[issue_tags[0]];
    assign issue_values[1] = values[issue_tags[1]];

    // Commit read by ROB head tag
    assign commit_value_out = values[rd_tags[2]];

endmodule

// File: design/alu_issue_queue.sv
// ALU reservation station: bus wakeup and oldest-ready issue selection
`timescale 1ns/1ps

module alu_issue_queue (
    input  logic               clk,
    input  logic               reset,
    input  logic               disp_valid,
    input  ooo_pkg::dispatch_t disp,
    input  ooo_pkg::cdb_t      cdb,
    output ooo_pkg::issue_t    iss,
    output logic               full
);
    import ooo_pkg::*;

    dispatch_t               entries [iq_depth];
    logic [iq_depth-1:0]     valid;
    // Age is the count of younger entries still queued
    logic [iq_idx_width-1:0] age [iq_depth];
    logic [iq_depth-1:0]     eligible;
    logic                    enq;
    dispatch_t               disp_woken;
    logic                    sel_found;
    logic [iq_idx_width-1:0] sel_idx;
    logic [iq_idx_width-1:0] sel_age;
    logic [iq_idx_width-1:0] free_idx;

    // x0 writes are done at dispatch in the ROB, never queued
    assign enq  = disp_valid && disp.writes_reg;
    assign full = &valid;

    // Same-cycle wakeup for the incoming packet
    always_comb begin
        disp_woken = disp;
        if (cdb.valid && cdb.tag == disp.src1_tag) begin
            disp_woken.src1_ready = 1'b1;
        end
        if (cdb.valid && cdb.tag == disp.src2_tag) begin
            disp_woken.src2_ready = 1'b1;
        end
    end

    // ========================================================================
    // Selection
    // ========================================================================
    always_comb begin
        for (int i = 0; i < iq_depth; i++) begin
            eligible[i] = valid[i] && entries[i].src1_ready && entries[i].src2_ready;
        end
    end

    // Oldest = largest age among eligible
    always_comb begin
        sel_found = 1'b0;
        sel_idx   = '0;
        sel_age   = '0;
        for (int i = 0; i < iq_depth; i++) begin
            if (eligible[i] && (!sel_found || age[i] > sel_age)) begin
                sel_found = 1'b1;
                sel_idx   = iq_idx_width'(i);
                sel_age   = age[i];
            end
        end
    end

    // Lowest free slot
    always_comb begin
        free_idx = '0;
        for (int i = iq_depth - 1; i >= 0; i--) begin
            if (!valid[i]) begin
                free_idx = iq_idx_width'(i);
            end
        end
    end

    always_comb begin
        iss.valid    = sel_found;
        iss.op       = entries[sel_idx].op;
        iss.src1_tag = entries[sel_idx].src1_tag;
        iss.src2_tag = entries[sel_idx].src2_tag;
        iss.imm      = entries[sel_idx].imm;
        iss.use_imm  = entries[sel_idx].use_imm;
        iss.dst_tag  = entries[sel_idx].dst_tag;
    end

    // ========================================================================
    // Entry update
    // ========================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;
        end else begin
            for (int i = 0; i < iq_depth; i++) begin
                // One more younger on enqueue, one fewer when a younger leaves
                if (valid[i]) begin
                    age[i] <= age[i] + iq_idx_width'(enq)
                                     - iq_idx_width'(sel_found && age[i] > sel_age);
                end
                // Bus wakeup
                if (cdb.valid && entries[i].src1_tag == cdb.tag) begin
                    entries[i].src1_ready <= 1'b1;
                end
                if (cdb.valid && entries[i].src2_tag == cdb.tag) begin
                    entries[i].src2_ready <= 1'b1;
                end
            end
            if (sel_found) begin
                valid[sel_idx] <= 1'b0;
            end
            if (enq) begin
                valid[free_idx]   <= 1'b1;
                entries[free_idx] <= disp_woken;
                age[free_idx]     <= '0;
            end
        end
    end

endmodule

// File: design/alu_unit.sv
// Single-cycle ALU, result registered onto the common data bus
`timescale 1ns/1ps

module alu_unit (
    input  logic                          clk,
    input  logic                          reset,
    input  ooo_pkg::issue_t               iss,
    input  logic [1:0][ooo_pkg::xlen-1:0] src_values,
    output ooo_pkg::cdb_t                 cdb
);
    import ooo_pkg::*;

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] result;

    assign op_a = src_values[0];
    // Immediate replaces rs2
    assign op_b = iss.use_imm ? iss.imm : src_values[1];

    // Shifts use the low five bits only
    always_comb begin
        case (iss.op)
            alu_add:  result = op_a + op_b;
            alu_sub:  result = op_a - op_b;
            alu_and:  result = op_a & op_b;
            alu_or:   result = op_a | op_b;
            alu_xor:  result = op_a ^ op_b;
            alu_slt:  result = {{(xlen - 1){1'b0}}, $signed(op_a) < $signed(op_b)};
            alu_sltu: result = {{(xlen - 1){1'b0}}, op_a < op_b};
            alu_sll:  result = op_a << op_b[4:0];
            alu_srl:  result = op_a >> op_b[4:0];
            alu_sra:  result = $signed(op_a) >>> op_b[4:0];
            default:  result = '0;
        endcase
    end

    // Broadcast one cycle after issue
    always_ff @(posedge clk) begin
        if (reset) begin
            cdb.valid <= 1'b0;
        end else begin
            cdb.valid <= iss.valid;
        end
        cdb.tag   <= iss.dst_tag;
        cdb.value <= result;
    end

endmodule

// File: design/reorder_buffer.sv
// Reorder buffer: in-order completion tracking, commit and architectural register view
`timescale 1ns/1ps

module reorder_buffer (
    input  logic                                                  clk,
    input  logic                                                  reset,
    input  logic                                                  disp_valid,
    input  ooo_pkg::dispatch_t                                    disp,
    input  ooo_pkg::cdb_t                                         cdb,
    output logic                                                  full,
    output logic [ooo_pkg::phys_tag_width-1:0]                    commit_tag,
    input  logic [ooo_pkg::xlen-1:0]                              commit_data,
    output logic                                                  free_en,
    output logic [ooo_pkg::phys_tag_width-1:0]                    free_tag,
    output logic                                                  commit_valid,
    output logic [ooo_pkg::arch_addr_width-1:0]                   commit_rd,
    output logic [ooo_pkg::xlen-1:0]                              commit_value,
    output logic [ooo_pkg::num_arch_regs-1:0][ooo_pkg::xlen-1:0] arch_regs
);
    import ooo_pkg::*;

    // Only order is tracked here and values stay in the PRF
    logic [arch_addr_width-1:0] rob_rd [rob_depth];
    logic [phys_tag_width-1:0]  rob_dst [rob_depth];
    logic [phys_tag_width-1:0]  rob_old [rob_depth];
    logic [rob_depth-1:0]       rob_writes;
    logic [rob_depth-1:0]       rob_done;
    logic [rob_ptr_width-1:0]   head;
    logic [rob_ptr_width-1:0]   tail;
    logic [rob_ptr_width:0]     count;

    assign full = count == (rob_ptr_width + 1)'(rob_depth);

    // ========================================================================
    // Commit from head
    // ========================================================================
    assign commit_valid = (count != '0) && rob_done[head];
    assign commit_tag   = rob_dst[head];
    assign commit_rd    = rob_rd[head];
    assign commit_value = commit_data;
    // Previous mapping of rd goes back to the free list
    assign free_en      = commit_valid && rob_writes[head];
    assign free_tag     = rob_old[head];

    always_ff @(posedge clk) begin
        if (reset) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            rob_done  <= '0;
            arch_regs <= '0;
        end else begin
            // Completion by destination tag
            for (int i = 0; i < rob_depth; i++) begin
                if (cdb.valid && rob_dst[i] == cdb.tag) begin
                    rob_done[i] <= 1'b1;
                end
            end
            if (disp_valid) begin
                rob_rd[tail]     <= disp.arch_rd;
                rob_dst[tail]    <= disp.dst_tag;
                rob_old[tail]    <= disp.old_tag;
                rob_writes[tail] <= disp.writes_reg;
                // x0 writes never execute
                rob_done[tail]   <= !disp.writes_reg;
                tail             <= tail + 1'b1;
            end
            if (commit_valid) begin
                head <= head + 1'b1;
                if (commit_rd != '0) begin
                    arch_regs[commit_rd] <= commit_data;
                end
            end
            count <= count + {{rob_ptr_width{1'b0}}, disp_valid}
                           - {{rob_ptr_width{1'b0}}, commit_valid};
        end
    end

endmodule

// File: design/ooo_core_top.sv
// Out-of-order core top level: rename, PRF, issue queue, ALU and ROB with stall level
`timescale 1ns/1ps

module ooo_core_top (
    input  logic                                                  clk,
    input  logic                                                  reset,
    input  ooo_pkg::instr_word_u                                  instr,
    input  logic                                                  instr_valid,
    output logic                                                  stall,
    output logic                                                  commit_valid,
    output logic [ooo_pkg::arch_addr_width-1:0]                   commit_rd,
    output logic [ooo_pkg::xlen-1:0]                              commit_value,
    output logic [ooo_pkg::num_arch_regs-1:0][ooo_pkg::xlen-1:0] arch_regs
);
    import ooo_pkg::*;

    logic                           accept;
    logic                           iq_full;
    logic                           rob_full;
    logic                           free_empty;
    logic                           disp_valid;
    logic                           free_en;
    logic [1:0]                     src_ready;
    logic [1:0][phys_tag_width-1:0] src_tags;
    logic [phys_tag_width-1:0]      free_tag;
    logic [phys_tag_width-1:0]      commit_tag;
    logic [xlen-1:0]                commit_data;
    logic [1:0][xlen-1:0]           issue_values;
    dispatch_t                      disp;
    issue_t                         iss;
    cdb_t                           cdb;

    // ========================================================================
    // Stall and accept
    // ========================================================================
    assign stall  = iq_full | rob_full | free_empty;
    assign accept = instr_valid && !stall;

    rename_stage u_rename (
        .clk(clk), .reset(reset), .instr(instr), .accept(accept),
        .src_ready(src_ready), .src_tags(src_tags),
        .free_en(free_en), .free_tag(free_tag), .free_empty(free_empty),
        .disp_valid(disp_valid), .disp(disp)
    );

    // Two rename ports plus the commit port
    phys_reg_file u_prf (
        .clk(clk), .reset(reset), .cdb(cdb),
        .alloc_en(disp_valid && disp.writes_reg), .alloc_tag(disp.dst_tag),
        .rd_tags({commit_tag, src_tags}), .issue_tags({iss.src2_tag, iss.src1_tag}),
        .ready(src_ready), .issue_values(issue_values), .commit_value_out(commit_data)
    );

    alu_issue_queue u_iq (
        .clk(clk), .reset(reset), .disp_valid(disp_valid), .disp(disp),
        .cdb(cdb), .iss(iss), .full(iq_full)
    );

    alu_unit u_alu (
        .clk(clk), .reset(reset), .iss(iss), .src_values(issue_values), .cdb(cdb)
    );

    reorder_buffer u_rob (
        .clk(clk), .reset(reset), .disp_valid(disp_valid), .disp(disp), .cdb(cdb),
        .full(rob_full), .commit_tag(commit_tag), .commit_data(commit_data),
        .free_en(free_en), .free_tag(free_tag),
        .commit_valid(commit_valid), .commit_rd(commit_rd), .commit_value(commit_value),
        .arch_regs(arch_regs)
    );

endmodule

// File: test/ooo_core_sva.sv
// Core protocol assertions on commit outputs and the common data bus
`timescale 1ns/1ps

module ooo_core_sva (
    input logic                               clk,
    input logic                               reset,
    input logic                               commit_valid,
    input logic [ooo_pkg::arch_addr_width-1:0] commit_rd,
    input logic                               disp_valid,
    input ooo_pkg::cdb_t                      cdb
);
    import ooo_pkg::*;

    // Commit strobe always driven out of reset
    commit_valid_known: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(commit_valid))
        else $error("commit_valid is unknown");

    // Tag 0 is the constant-zero register, never produced
    bus_tag_nonzero: assert property (@(posedge clk) disable iff (reset)
        cdb.valid |-> cdb.tag != '0)
        else $error("valid bus result carries tag 0");

    // Head rd moves only on a commit, or a dispatch into an empty ROB
    commit_rd_steady: assert property (@(posedge clk) disable iff (reset)
        !$stable(commit_rd) |-> ($past(commit_valid) || $past(disp_valid)))
        else $error("commit_rd changed without a commit or dispatch");

endmodule

// File: test/tb_ooo_core.sv
// Testbench for the out-of-order core: random ALU stream checked against an in-order model
`timescale 1ns/1ps

module tb_ooo_core;
    import ooo_pkg::*;

    localparam int num_instrs = 2000;
    localparam int clk_period = 4;
    // Worst case about four cycles per instruction, plus drain slack
    localparam int max_cycles = num_instrs * 4 + 200;

    logic                               clk;
    logic                               reset;
    instr_word_u                        instr;
    logic                               instr_valid;
    logic                               stall;
    logic                               commit_valid;
    logic [arch_addr_width-1:0]         commit_rd;
    logic [xlen-1:0]                    commit_value;
    logic [num_arch_regs-1:0][xlen-1:0] arch_regs;

    logic [31:0] rng_state;
    logic [31:0] model_regs [num_arch_regs];
    // Accepted instruction words, oldest first
    logic [31:0] pending [$];
    int          errors;
    int          accepted;
    int          commits;
    int          zero_commits;
    int          cycles;

    ooo_core_top u_dut (
        .clk(clk), .reset(reset), .instr(instr), .instr_valid(instr_valid), .stall(stall),
        .commit_valid(commit_valid), .commit_rd(commit_rd), .commit_value(commit_value),
        .arch_regs(arch_regs)
    );

    bind ooo_core_top ooo_core_sva u_sva (
        .clk(clk), .reset(reset), .commit_valid(commit_valid), .commit_rd(commit_rd),
        .disp_valid(disp_valid), .cdb(cdb)
    );

    always #(clk_period / 2) clk = ~clk;

    // ========================================================================
    // Helpers
    // ========================================================================
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("Fail at %0t ns: %s = %h, expected %h", $time, name, got, expected);
            errors++;
        end
    endtask

    // 32-bit xorshift, state advances on every draw
    function logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Narrow mode packs all operands into x0..x3 for dense dependencies
    function automatic logic [31:0] make_instr(input logic narrow);
        logic [31:0] r;
        logic [31:0] s;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        logic [31:0] word;
        r   = next_random();
        s   = next_random();
        rd  = narrow ? {3'b000, r[1:0]} : r[4:0];
        rs1 = narrow ? {3'b000, r[6:5]} : r[9:5];
        rs2 = narrow ? {3'b000, r[11:10]} : r[14:10];
        f3  = r[17:15];
        // Bit 30 set only for sub, sra and srai
        f7  = ((f3 == 3'b000 || f3 == 3'b101) && r[18]) ? 7'b0100000 : 7'b0000000;
        if (f3 == 3'b001) begin
            imm = {7'b0000000, s[4:0]};
        end else if (f3 == 3'b101) begin
            imm = {f7, s[4:0]};
        end else begin
            imm = s[11:0];
        end
        if (r[19]) begin
            word = {f7, rs2, rs1, f3, rd, 7'b0110011};
        end else begin
            word = {imm, rs1, f3, rd, 7'b0010011};
        end
        return word;
    endfunction

    // RV32I result from the raw word and the two register reads
    function automatic logic [31:0] model_result(input logic [31:0] word,
                                                 input logic [31:0] a,
                                                 input logic [31:0] b_reg);
        logic        is_imm;
        logic [31:0] b;
        logic [31:0] res;
        is_imm = word[6:0] == 7'b0010011;
        b      = is_imm ? {{20{word[31]}}, word[31:20]} : b_reg;
        case (word[14:12])
            3'b000:  res = (!is_imm && word[30]) ? a - b : a + b;
            3'b001:  res = a << b[4:0];
            3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  res = (a < b) ? 32'd1 : 32'd0;
            3'b100:  res = a ^ b;
            3'b110:  res = a | b;
            3'b111:  res = a & b;
            default: begin
                if (word[30]) begin
                    res = $signed(a) >>> b[4:0];
                end else begin
                    res = a >> b[4:0];
                end
            end
        endcase
        return res;
    endfunction

    task automatic process_commit();
        logic [31:0] word;
        logic [31:0] expected;
        logic [4:0]  rd;
        if (pending.size() == 0) begin
            $display("Error at %0t ns: commit seen with no accepted instruction left", $time);
            errors++;
        end else begin
            word     = pending.pop_front();
            rd       = word[11:7];
            expected = model_result(word, model_regs[word[19:15]], model_regs[word[24:20]]);
            check_value("commit_rd", 32'(commit_rd), 32'(rd));
            if (rd == 5'd0) begin
                // x0 stays zero in the architectural view
                zero_commits++;
                check_value("arch_regs[0]", arch_regs[0], 32'h0);
            end else begin
                check_value("commit_value", commit_value, expected);
                model_regs[rd] = expected;
            end
        end
        commits++;
    endtask

    // Commit outputs settle well before the falling edge
    always @(negedge clk) begin
        if (!reset && commit_valid) begin
            process_commit();
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout: stream not drained after %0d cycles", max_cycles);
            $display("sim failed");
            $finish;
        end
    end

    // ========================================================================
    // Main sequence
    // ========================================================================
    initial begin
        logic [31:0] r;
        logic        narrow;
        int          issued;
        clk          = 1'b0;
        reset        = 1'b1;
        instr        = '0;
        instr_valid  = 1'b0;
        rng_state    = 32'd94237;
        errors       = 0;
        accepted     = 0;
        commits      = 0;
        zero_commits = 0;
        cycles       = 0;
        issued       = 0;
        for (int i = 0; i < num_arch_regs; i++) begin
            model_regs[i] = '0;
        end
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        // Post-reset state
        check_value("stall", 32'(stall), 32'h0);
        check_value("commit_valid", 32'(commit_valid), 32'h0);
        for (int i = 0; i < num_arch_regs; i++) begin
            check_value($sformatf("arch_regs[%0d]", i), arch_regs[i], 32'h0);
        end

        // Alternate 64-instruction blocks of narrow and wide register use
        while (issued < num_instrs) begin
            @(posedge clk);
            #1;
            r      = next_random();
            narrow = issued[6];
            if (r[1:0] != 2'b00 && !stall) begin
                instr       = make_instr(narrow);
                instr_valid = 1'b1;
                pending.push_back(instr);
                issued++;
                accepted++;
            end else begin
                instr_valid = 1'b0;
            end
        end
        @(posedge clk);
        #1;
        instr_valid = 1'b0;

        // Drain, then let the last commit land in arch_regs
        while (commits < accepted) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        check_value("commit count", commits, accepted);
        check_value("pending size", pending.size(), 32'h0);
        check_value("commit_valid", 32'(commit_valid), 32'h0);
        check_value("stall", 32'(stall), 32'h0);
        for (int i = 0; i < num_arch_regs; i++) begin
            check_value($sformatf("arch_regs[%0d]", i), arch_regs[i], model_regs[i]);
        end

        $display("Commits %0d, x0 commits %0d, errors %0d", commits, zero_commits, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: list.f
design/ooo_pkg.sv
design/rename_stage.sv
design/phys_reg_file.sv
design/alu_issue_queue.sv
design/alu_unit.sv
design/reorder_buffer.sv
design/ooo_core_top.sv
test/ooo_core_sva.sv
test/tb_ooo_core.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the out-of-order core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_ooo_core -f list.f -o tb_ooo_core

output=$(./obj_dir/tb_ooo_core)
echo "$output"

if echo "$output" | grep -qx "sim passed"; then
    exit 0
fi
exit 1
